//--- logic/rom_ctrl_pkg.sv
/*
 * ROM controller shared definitions
 * Widths, multi-bit select encoding, scrambling rules and digest fold
 */
package rom_ctrl_pkg;

  localparam int AddrW = 8;
  localparam int Depth = 256;
  localparam int DataW = 32;

  // Address permutation key and keystream seed
  localparam logic [AddrW-1:0] ScrAddrKey = 8'hA5;
  localparam logic [DataW-1:0] ScrDataKey = 32'h9E37_79B9;
  localparam logic [DataW-1:0] DigestInit = 32'h6A09_E667;

  // Multi-bit select, only these two encodings are legal
  typedef enum logic [3:0] {
    MuBi4True  = 4'h6,
    MuBi4False = 4'h9
  } mubi4_t;

  function automatic logic mubi4_test_true_strict(mubi4_t val);
    return val == MuBi4True;
  endfunction

  function automatic logic mubi4_test_false_loose(mubi4_t val);
    return val != MuBi4True;
  endfunction

  function automatic logic mubi4_test_true_loose(mubi4_t val);
    return val != MuBi4False;
  endfunction

  function automatic logic mubi4_test_invalid(mubi4_t val);
    return (val != MuBi4True) && (val != MuBi4False);
  endfunction

  // Bitwise combine, OR on the set bits of True and AND on the others
  function automatic mubi4_t mubi4_or_hi(mubi4_t a, mubi4_t b);
    logic [3:0] act;
    logic [3:0] res;
    act = MuBi4True;
    for (int k = 0; k < 4; k++) begin
      res[k] = act[k] ? (a[k] | b[k]) : (a[k] & b[k]);
    end
    return mubi4_t'(res);
  endfunction

  // Physical index of a logical address
  function automatic logic [AddrW-1:0] rom_scr_addr(logic [AddrW-1:0] addr);
    return addr ^ ScrAddrKey;
  endfunction

  // Seed rotated left by the address, then the address mixed in
  function automatic logic [DataW-1:0] rom_keystream(logic [AddrW-1:0] addr);
    logic [2*DataW-1:0] dbl;
    dbl = {ScrDataKey, ScrDataKey} << addr[4:0];
    return dbl[2*DataW-1:DataW] ^ DataW'(addr);
  endfunction

  function automatic logic [DataW-1:0] rom_clear_word(logic [AddrW-1:0] addr);
    return {addr, ~addr, addr ^ 8'h3C, addr + 8'h11};
  endfunction

  function automatic logic [DataW-1:0] rom_digest_step(logic [DataW-1:0] digest,
                                                       logic [DataW-1:0] word);
    return {digest[DataW-2:0], digest[DataW-1]} ^ word;
  endfunction

endpackage

//--- logic/rom_port_if.sv
/*
 * ROM request/response port
 * One-cycle read, request side and response side as modports
 */
interface rom_port_if import rom_ctrl_pkg::*; ();

  // Request, logical and physical address
  logic             req;
  logic [AddrW-1:0] addr;
  logic [AddrW-1:0] scr_addr;

  // Response, one cycle after the request
  logic             rvalid;
  logic [DataW-1:0] scr_rdata;
  logic [DataW-1:0] clr_rdata;

  modport requester (
    output req,
    output addr,
    output scr_addr,
    input  rvalid,
    input  scr_rdata,
    input  clr_rdata
  );

  modport responder (
    input  req,
    input  addr,
    input  scr_addr,
    output rvalid,
    output scr_rdata,
    output clr_rdata
  );

endinterface

//--- logic/rom_digest_checker.sv
/*
 * ROM startup checker
 * Sweeps all words once, folds the scrambled data into a digest and
 * hands the ROM to the bus only on a digest match
 */
module rom_digest_checker import rom_ctrl_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic [DataW-1:0]     exp_digest_i,
  rom_port_if.requester        chk,
  output mubi4_t               sel_bus_o,
  output logic                 check_done_o,
  output logic                 check_good_o
);

  // Request side state
  logic [AddrW-1:0] addr_q;
  logic             issue_done_q;

  // Response side state
  logic [AddrW-1:0] rsp_cnt_q;
  logic             rsp_done_q;
  logic [DataW-1:0] digest_q;

  // Verdict, held until reset
  logic             check_done_q;
  logic             check_good_q;

  // One request per cycle until the last address went out
  assign chk.req      = ~issue_done_q;
  assign chk.addr     = addr_q;
  // Checker reads raw storage, physical index equals the sweep address
  assign chk.scr_addr = addr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q       <= '0;
      issue_done_q <= 1'b0;
    end else if (!issue_done_q) begin
      addr_q <= addr_q + 1'b1;
      if (addr_q == AddrW'(Depth - 1)) begin
        issue_done_q <= 1'b1;
      end
    end
  end

  // Fold each scrambled word as it comes back
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_cnt_q  <= '0;
      rsp_done_q <= 1'b0;
      digest_q   <= DigestInit;
    end else if (chk.rvalid && !rsp_done_q) begin
      digest_q  <= rom_digest_step(digest_q, chk.scr_rdata);
      rsp_cnt_q <= rsp_cnt_q + 1'b1;
      if (rsp_cnt_q == AddrW'(Depth - 1)) begin
        rsp_done_q <= 1'b1;
      end
    end
  end

  // Decide once, the cycle after the last fold
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      check_done_q <= 1'b0;
      check_good_q <= 1'b0;
    end else if (rsp_done_q && !check_done_q) begin
      check_done_q <= 1'b1;
      check_good_q <= (digest_q == exp_digest_i);
    end
  end

  assign check_done_o = check_done_q;
  assign check_good_o = check_good_q;

  // Bus owns the ROM from the good verdict on
  assign sel_bus_o = check_good_q ? MuBi4True : MuBi4False;

endmodule

//--- logic/rom_ctrl_mux.sv
/*
 * One-way ROM mux
 * Routes checker or bus requests to the array, guards the multi-bit
 * select and flags corrupt or reverting select values
 */
module rom_ctrl_mux import rom_ctrl_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  mubi4_t           sel_bus_i,
  rom_port_if.responder    chk,
  input  logic             bus_req_i,
  input  logic [AddrW-1:0] bus_addr_i,
  output logic             bus_gnt_o,
  output logic [DataW-1:0] bus_rdata_o,
  output logic             bus_rvalid_o,
  rom_port_if.requester    rom,
  output logic             alert_o
);

  // Sticky select and a one-cycle delayed copy of it
  mubi4_t sel_bus_q;
  mubi4_t sel_bus_qq;

  logic   sel_invalid;
  logic   sel_reverted;
  logic   sel_q_reverted;
  logic   alert_d;
  logic   alert_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_bus_q  <= MuBi4False;
      sel_bus_qq <= MuBi4False;
    end else begin
      // Once true stays true
      sel_bus_q  <= mubi4_or_hi(sel_bus_q, sel_bus_i);
      sel_bus_qq <= sel_bus_q;
    end
  end

  // Corrupt encoding on the input or in the register
  assign sel_invalid = mubi4_test_invalid(sel_bus_i) | mubi4_test_invalid(sel_bus_q);

  // Input fell back to the checker after the bus had it
  assign sel_reverted = mubi4_test_true_loose(sel_bus_q) & mubi4_test_false_loose(sel_bus_i);

  // The register itself fell back
  assign sel_q_reverted = mubi4_test_true_loose(sel_bus_qq) & mubi4_test_false_loose(sel_bus_q);

  assign alert_d = sel_invalid | sel_reverted | sel_q_reverted;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_q <= 1'b0;
    end else begin
      alert_q <= alert_d;
    end
  end

  assign alert_o = alert_q;

  // Bus may issue in every cycle with a strictly true select
  assign bus_gnt_o = mubi4_test_true_strict(sel_bus_i);

  assign rom.req      = bus_gnt_o ? bus_req_i : chk.req;
  assign rom.addr     = bus_gnt_o ? bus_addr_i : chk.addr;
  assign rom.scr_addr = bus_gnt_o ? rom_scr_addr(bus_addr_i) : chk.addr;

  // Response owner follows the select of the request cycle
  assign bus_rvalid_o = mubi4_test_true_strict(sel_bus_q) & rom.rvalid;
  assign bus_rdata_o  = rom.clr_rdata;

  // Checker only ever sees scrambled data
  assign chk.rvalid    = ~mubi4_test_true_strict(sel_bus_q) & rom.rvalid;
  assign chk.scr_rdata = rom.scr_rdata;
  assign chk.clr_rdata = rom.scr_rdata;

endmodule

//--- logic/rom_scr_array.sv
/*
 * Scrambled ROM array
 * One-cycle read returning both scrambled and descrambled words
 */
module rom_scr_array import rom_ctrl_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,
  rom_port_if.responder rom
);

  logic [DataW-1:0] mem [Depth];

  // Read pipeline
  logic             rvalid_q;
  logic [DataW-1:0] scr_rdata_q;
  logic [DataW-1:0] clr_rdata_q;
  logic [DataW-1:0] scr_word;

  // Image content, each word at its permuted index under its own keystream
  initial begin
    for (int i = 0; i < Depth; i++) begin
      mem[rom_scr_addr(AddrW'(i))] = rom_clear_word(AddrW'(i)) ^ rom_keystream(AddrW'(i));
    end
  end

  // Lookup by physical index
  assign scr_word = mem[rom.scr_addr];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rom.req;
    end
  end

  // Data registers hold their value between reads
  always_ff @(posedge clk_i) begin
    if (rom.req) begin
      scr_rdata_q <= scr_word;
      // Keystream of the sampled logical address
      clr_rdata_q <= scr_word ^ rom_keystream(rom.addr);
    end
  end

  assign rom.rvalid    = rvalid_q;
  assign rom.scr_rdata = scr_rdata_q;
  assign rom.clr_rdata = clr_rdata_q;

endmodule

//--- logic/rom_ctrl_top.sv
/*
 * ROM controller top
 * Startup checker, one-way mux and scrambled array in a chain
 */
module rom_ctrl_top import rom_ctrl_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [DataW-1:0] exp_digest_i,
  input  logic             bus_req_i,
  input  logic [AddrW-1:0] bus_addr_i,
  output logic             bus_gnt_o,
  output logic [DataW-1:0] bus_rdata_o,
  output logic             bus_rvalid_o,
  output logic             check_done_o,
  output logic             check_good_o,
  output logic             alert_o
);

  // Checker to mux, and mux to array
  rom_port_if chk_port ();
  rom_port_if rom_port ();

  // Bus ownership select from the checker
  mubi4_t sel_bus;

  rom_digest_checker u_rom_digest_checker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .exp_digest_i (exp_digest_i),
    .chk          (chk_port.requester),
    .sel_bus_o    (sel_bus),
    .check_done_o (check_done_o),
    .check_good_o (check_good_o)
  );

  rom_ctrl_mux u_rom_ctrl_mux (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .sel_bus_i    (sel_bus),
    .chk          (chk_port.responder),
    .bus_req_i    (bus_req_i),
    .bus_addr_i   (bus_addr_i),
    .bus_gnt_o    (bus_gnt_o),
    .bus_rdata_o  (bus_rdata_o),
    .bus_rvalid_o (bus_rvalid_o),
    .rom          (rom_port.requester),
    .alert_o      (alert_o)
  );

  rom_scr_array u_rom_scr_array (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .rom    (rom_port.responder)
  );

endmodule

//--- tests/rom_ctrl_sva.sv
/*
 * ROM mux assertions
 * Grant monotonicity, bus response ownership and alert quietness
 */
module rom_ctrl_sva import rom_ctrl_pkg::*; (
  input logic   clk_i,
  input logic   rst_ni,
  input mubi4_t sel_bus_i,
  input mubi4_t sel_bus_q_i,
  input mubi4_t sel_bus_qq_i,
  input logic   bus_gnt_i,
  input logic   bus_rvalid_i,
  input logic   alert_i
);

  timeunit 1ns;
  timeprecision 1ps;

  logic sel_ok;

  // Legal encodings, and no step back from bus to checker at either stage
  assign sel_ok = !mubi4_test_invalid(sel_bus_i) && !mubi4_test_invalid(sel_bus_q_i) &&
                  !(sel_bus_q_i == MuBi4True && sel_bus_i != MuBi4True) &&
                  !(sel_bus_qq_i == MuBi4True && sel_bus_q_i != MuBi4True);

  gnt_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_gnt_i |=> bus_gnt_i)
    else $error("bus grant fell after it had risen");

  // A bus response belongs to a request granted one cycle earlier
  rvalid_owned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_rvalid_i |-> $past(bus_gnt_i))
    else $error("bus rvalid without a grant in the previous cycle");

  alert_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sel_ok |=> !alert_i)
    else $error("alert raised with a legal monotonic select");

endmodule

bind rom_ctrl_mux rom_ctrl_sva u_rom_ctrl_sva (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .sel_bus_i    (sel_bus_i),
  .sel_bus_q_i  (sel_bus_q),
  .sel_bus_qq_i (sel_bus_qq),
  .bus_gnt_i    (bus_gnt_o),
  .bus_rvalid_i (bus_rvalid_o),
  .alert_i      (alert_o)
);

//--- tests/rom_ctrl_tb.sv
/*
 * ROM controller testbench
 * Startup check with good and wrong digests, random bus reads against
 * reference words, alert watch
 */
module rom_ctrl_tb import rom_ctrl_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [15:0] LfsrSeed  = 16'd45346;
  localparam int          NumReads  = 64;
  localparam int          NumEarly  = 16;
  localparam int          DoneWait  = Depth + 32;
  localparam int          DrainWait = 16;

  logic             clk_i;
  logic             rst_ni;
  logic [DataW-1:0] exp_digest_i;
  logic             bus_req_i;
  logic [AddrW-1:0] bus_addr_i;
  logic             bus_gnt_o;
  logic [DataW-1:0] bus_rdata_o;
  logic             bus_rvalid_o;
  logic             check_done_o;
  logic             check_good_o;
  logic             alert_o;

  logic [15:0]      lfsr_q;
  // Expected bus words, one per granted request
  logic [DataW-1:0] exp_q [$];
  int unsigned      check_cnt;
  int unsigned      err_cnt;
  int unsigned      alert_err;
  int unsigned      test_cnt;

  rom_ctrl_top u_rom_ctrl_top (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .exp_digest_i (exp_digest_i),
    .bus_req_i    (bus_req_i),
    .bus_addr_i   (bus_addr_i),
    .bus_gnt_o    (bus_gnt_o),
    .bus_rdata_o  (bus_rdata_o),
    .bus_rvalid_o (bus_rvalid_o),
    .check_done_o (check_done_o),
    .check_good_o (check_good_o),
    .alert_o      (alert_o)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #20 clk_i = ~clk_i;
    end
  end

  // Galois LFSR, taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int k = 0; k < n; k++) begin
      val    = {val[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  // Sweep walks physical indices, the address key maps each back to its logical address
  function automatic logic [DataW-1:0] ref_digest();
    logic [DataW-1:0] d;
    logic [AddrW-1:0] la;
    d = DigestInit;
    for (int i = 0; i < Depth; i++) begin
      la = rom_scr_addr(AddrW'(i));
      d  = rom_digest_step(d, rom_clear_word(la) ^ rom_keystream(la));
    end
    return d;
  endfunction

  function automatic logic [DataW-1:0] ref_bus_word(logic [AddrW-1:0] addr);
    return rom_clear_word(addr);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic apply_reset(input logic [DataW-1:0] digest);
    @(negedge clk_i);
    rst_ni       = 1'b0;
    bus_req_i    = 1'b0;
    exp_digest_i = digest;
    exp_q.delete();
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
  endtask

  // Request one word, expected data only when the grant is up
  task automatic bus_read(input logic [AddrW-1:0] addr, input logic expect_gnt);
    @(negedge clk_i);
    bus_req_i  = 1'b1;
    bus_addr_i = addr;
    check_value("bus_gnt_o", 32'(bus_gnt_o), 32'(expect_gnt));
    if (bus_gnt_o) begin
      exp_q.push_back(ref_bus_word(addr));
    end
  endtask

  task automatic bus_idle(input int cycles);
    for (int c = 0; c < cycles; c++) begin
      @(negedge clk_i);
      bus_req_i = 1'b0;
    end
  endtask

  task automatic wait_check_done();
    int n;
    n = 0;
    while (!check_done_o && n < DoneWait) begin
      @(negedge clk_i);
      n++;
    end
    if (!check_done_o) begin
      err_cnt++;
      $display("Timed out waiting for check_done_o");
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < DrainWait) begin
      @(negedge clk_i);
      n++;
    end
    if (exp_q.size() != 0) begin
      err_cnt++;
      $display("Timed out with %0d bus reads unanswered", exp_q.size());
      exp_q.delete();
    end
  endtask

  task automatic report_test(input string name, input int unsigned errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("Test %0d %s: ok", test_cnt, name);
    end else begin
      $display("Test %0d %s: %0d errors", test_cnt, name, err_cnt - errs_before);
    end
  endtask

  // Response checker, sampled mid-cycle where registered outputs are stable
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (alert_o !== 1'b0) begin
        alert_err++;
      end
      check_value("alert_o", 32'(alert_o), 32'd0);
      if (bus_rvalid_o) begin
        if (exp_q.size() == 0) begin
          err_cnt++;
          $display("bus_rvalid_o rose with no granted request outstanding");
        end else begin
          check_value("bus_rdata_o", bus_rdata_o, exp_q.pop_front());
        end
      end
    end
  end

  initial begin
    logic [31:0]      rnd;
    logic [DataW-1:0] good_digest;
    int unsigned      errs;
    rst_ni       = 1'b0;
    exp_digest_i = '0;
    bus_req_i    = 1'b0;
    bus_addr_i   = '0;
    lfsr_q       = LfsrSeed;
    check_cnt    = 0;
    err_cnt      = 0;
    alert_err    = 0;
    test_cnt     = 0;
    good_digest  = ref_digest();

    // Reset values, then requests during the sweep are dropped
    errs = err_cnt;
    apply_reset(good_digest);
    check_value("bus_gnt_o", 32'(bus_gnt_o), 32'd0);
    check_value("bus_rvalid_o", 32'(bus_rvalid_o), 32'd0);
    check_value("check_done_o", 32'(check_done_o), 32'd0);
    check_value("check_good_o", 32'(check_good_o), 32'd0);
    check_value("alert_o", 32'(alert_o), 32'd0);
    for (int i = 0; i < NumEarly; i++) begin
      draw_bits(AddrW, rnd);
      bus_read(rnd[AddrW-1:0], 1'b0);
      check_value("bus_rvalid_o", 32'(bus_rvalid_o), 32'd0);
    end
    bus_idle(1);
    report_test("reset state and early requests", errs);

    errs = err_cnt;
    wait_check_done();
    check_value("check_done_o", 32'(check_done_o), 32'd1);
    check_value("check_good_o", 32'(check_good_o), 32'd1);
    check_value("bus_gnt_o", 32'(bus_gnt_o), 32'd1);
    report_test("good digest opens the bus", errs);

    // Random gaps of 0 to 3 idle cycles, back-to-back reads included
    errs = err_cnt;
    for (int i = 0; i < NumReads; i++) begin
      draw_bits(2, rnd);
      bus_idle(int'(rnd[1:0]));
      draw_bits(AddrW, rnd);
      bus_read(rnd[AddrW-1:0], 1'b1);
    end
    bus_idle(1);
    wait_drain();
    check_value("bus_gnt_o", 32'(bus_gnt_o), 32'd1);
    report_test("random bus reads", errs);

    errs = err_cnt;
    apply_reset(good_digest ^ 32'h1);
    wait_check_done();
    check_value("check_done_o", 32'(check_done_o), 32'd1);
    check_value("check_good_o", 32'(check_good_o), 32'd0);
    for (int i = 0; i < NumEarly; i++) begin
      draw_bits(AddrW, rnd);
      bus_read(rnd[AddrW-1:0], 1'b0);
      check_value("bus_rvalid_o", 32'(bus_rvalid_o), 32'd0);
    end
    bus_idle(2);
    check_value("bus_rvalid_o", 32'(bus_rvalid_o), 32'd0);
    report_test("wrong digest keeps the bus closed", errs);

    test_cnt++;
    if (alert_err == 0) begin
      $display("Test %0d alert stays low: ok", test_cnt);
    end else begin
      $display("Test %0d alert stays low: %0d errors", test_cnt, alert_err);
    end

    $display("Tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
logic/rom_ctrl_pkg.sv
logic/rom_port_if.sv
logic/rom_digest_checker.sv
logic/rom_ctrl_mux.sv
logic/rom_scr_array.sv
logic/rom_ctrl_top.sv
tests/rom_ctrl_sva.sv
tests/rom_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the ROM controller testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module rom_ctrl_tb \
  -f vlog.f -Mdir obj_dir -o Vrom_ctrl_tb &&
  ./obj_dir/Vrom_ctrl_tb 2>&1 | tee sim.log
grep -q "Simulation completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
